/* src/keypad_pkg.sv */
package keypad_pkg;

    // Row pattern in the upper nibble, column pattern in the lower, both active low.
    typedef logic [7:0] key_coord_t;
    typedef logic [3:0] key_val_t;
    typedef logic [15:0] entry_t; // Four hex digits.

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = 3;
    localparam int DEBOUNCE_DEFAULT = 2_000_000; // 20 ms at 100 MHz.
    localparam int COL_SETTLE = 3;               // Column change to valid synchronized rows.

    localparam key_val_t KEY_STAR = 4'd14;
    localparam key_val_t KEY_HASH = 4'd15;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_SWEEP   = 2'd1;
    localparam logic [1:0] ST_DELAY   = 2'd2;
    localparam logic [1:0] ST_RELEASE = 2'd3;

    // Line 0 sits on the MSB, matching the sweep order 0111, 1011, 1101, 1110.
    function automatic logic [1:0] line_index(input logic [3:0] lines);
        case (lines)
            4'b0111: return 2'd0;
            4'b1011: return 2'd1;
            4'b1101: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    function automatic key_val_t decode_key(input key_coord_t coord);
        logic [1:0] row_idx;
        logic [1:0] col_idx;
        row_idx = line_index(coord[7:4]);
        col_idx = line_index(coord[3:0]);
        if (row_idx == 2'd3) begin // Bottom row is * 0 # D.
            case (col_idx)
                2'd0:    return KEY_STAR;
                2'd1:    return 4'd0;
                2'd2:    return KEY_HASH;
                default: return 4'd13;
            endcase
        end
        if (col_idx == 2'd3) begin
            return 4'd10 + row_idx; // Letters A to C.
        end
        return row_idx * 4'd3 + col_idx + 4'd1;
    endfunction

endpackage

/* src/keypad_scan.sv */
`timescale 1ns/1ps

module keypad_scan #(
    parameter int debounce_cycles = keypad_pkg::DEBOUNCE_DEFAULT
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [3:0]             row_in,
    output logic [3:0]             col_out,
    output keypad_pkg::key_coord_t key_coord,
    output logic                   key_valid
);
    import keypad_pkg::*;

    logic [3:0] row_meta;
    logic [3:0] row_sync;
    logic [1:0] state;
    logic [$clog2(debounce_cycles + 1)-1:0] wait_cnt;
    logic [$clog2(COL_SETTLE + 1)-1:0]      settle_cnt;
    logic       second;  // Confirming sweep.
    logic       found;
    logic       multi;   // More than one column had a hit.
    key_coord_t cur_coord;
    key_coord_t first_coord;
    logic       first_multi;

    logic       row_hit;
    logic       sample;
    logic       last_col;
    logic       found_nx;
    logic       multi_nx;
    key_coord_t coord_nx;
    logic       accept;

    assign row_hit  = row_sync != 4'hf;
    assign sample   = (state == ST_SWEEP) && (settle_cnt == COL_SETTLE - 1);
    assign last_col = col_out == 4'b1110;

    // Hit state including the column being sampled now.
    assign found_nx = found | row_hit;
    assign multi_nx = multi | (found & row_hit);
    assign coord_nx = (row_hit && !found) ? {row_sync, col_out} : cur_coord;

    // Same key on both sweeps, one column and one row only.
    assign accept = found_nx && !multi_nx && !first_multi
                    && (coord_nx == first_coord)
                    && ($countones(~coord_nx[7:4]) == 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_meta <= 4'hf;
            row_sync <= 4'hf;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            col_out    <= 4'h0;
            key_valid  <= 1'b0;
            wait_cnt   <= '0;
            settle_cnt <= '0;
            second     <= 1'b0;
            found      <= 1'b0;
            multi      <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (row_hit) begin
                        state      <= ST_SWEEP;
                        col_out    <= 4'b0111;
                        settle_cnt <= '0;
                        second     <= 1'b0;
                    end
                end
                ST_SWEEP: begin
                    if (!sample) begin
                        settle_cnt <= settle_cnt + 1'b1;
                    end else begin
                        settle_cnt <= '0;
                        found      <= found_nx;
                        multi      <= multi_nx;
                        if (!last_col) begin
                            col_out <= {1'b1, col_out[3:1]}; // Next column.
                        end else begin
                            col_out  <= 4'h0;
                            wait_cnt <= '0;
                            found    <= 1'b0;
                            multi    <= 1'b0;
                            if (second) begin
                                key_valid <= accept;
                                state     <= ST_RELEASE;
                            end else if (found_nx) begin
                                state <= ST_DELAY;
                            end else begin
                                state <= ST_IDLE; // Bounce, nothing held.
                            end
                        end
                    end
                end
                ST_DELAY: begin
                    if (wait_cnt == debounce_cycles - 1) begin
                        state      <= ST_SWEEP;
                        col_out    <= 4'b0111;
                        settle_cnt <= '0;
                        second     <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_RELEASE: begin
                    // All rows must stay high for the full period.
                    if (row_hit) begin
                        wait_cnt <= '0;
                    end else if (wait_cnt == debounce_cycles - 1) begin
                        state <= ST_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            cur_coord <= coord_nx;
        end
        if (sample && last_col && !second) begin
            first_coord <= coord_nx;
            first_multi <= multi_nx;
        end
        if (sample && last_col && second) begin
            key_coord <= coord_nx; // Qualified by key_valid.
        end
    end

endmodule

/* src/key_fifo.sv */
`timescale 1ns/1ps

module key_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  keypad_pkg::key_coord_t push_coord,
    input  logic                   pop,
    output keypad_pkg::key_coord_t head_coord,
    output logic                   not_empty,
    output logic                   overflow
);
    import keypad_pkg::*;

    key_coord_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_pop  = pop && (count != 0);
    // A pop in the same cycle makes room in a full FIFO.
    assign do_push = push && ((count != FIFO_DEPTH) || do_pop);

    assign head_coord = mem[rd_ptr]; // Show-ahead.
    assign not_empty  = count != 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push) begin
                overflow <= 1'b1; // Sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_coord;
        end
    end

endmodule

/* src/digit_entry.sv */
`timescale 1ns/1ps

module digit_entry (
    input  logic                   clk,
    input  logic                   rst_n,
    input  keypad_pkg::key_coord_t head_coord,
    input  logic                   not_empty,
    input  logic                   hold,
    output logic                   pop,
    output keypad_pkg::entry_t     entry,
    output keypad_pkg::entry_t     commit_value,
    output logic                   commit_valid
);
    import keypad_pkg::*;

    key_val_t key;
    logic     is_hash;

    // Take the head whenever something is queued and the consumer is not held.
    assign pop     = not_empty && !hold;
    assign key     = decode_key(head_coord);
    assign is_hash = key == KEY_HASH;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            entry        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= 1'b0;
            if (pop) begin
                case (key)
                    KEY_STAR: begin
                        entry <= '0;
                    end
                    KEY_HASH: begin
                        entry        <= '0;
                        commit_valid <= 1'b1;
                    end
                    default: begin
                        entry <= {entry[11:0], key}; // Oldest digit drops off.
                    end
                endcase
            end
        end
    end

    // Entry as it stood before the # clears it.
    always_ff @(posedge clk) begin
        if (pop && is_hash) begin
            commit_value <= entry;
        end
    end

endmodule

/* src/keypad_top.sv */
`timescale 1ns/1ps

module keypad_top #(
    parameter int debounce_cycles = keypad_pkg::DEBOUNCE_DEFAULT
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [3:0]         row_in,
    input  logic               hold,
    output logic [3:0]         col_out,
    output keypad_pkg::entry_t entry,
    output keypad_pkg::entry_t commit_value,
    output logic               commit_valid,
    output logic               overflow
);
    import keypad_pkg::*;

    key_coord_t key_coord;
    logic       key_valid;
    key_coord_t head_coord;
    logic       not_empty;
    logic       pop;

    keypad_scan #(
        .debounce_cycles(debounce_cycles)
    ) i_keypad_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .row_in   (row_in),
        .col_out  (col_out),
        .key_coord(key_coord),
        .key_valid(key_valid)
    );

    // No back-pressure; presses beyond the depth are dropped.
    key_fifo i_key_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (key_valid),
        .push_coord(key_coord),
        .pop       (pop),
        .head_coord(head_coord),
        .not_empty (not_empty),
        .overflow  (overflow)
    );

    digit_entry i_digit_entry (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_coord  (head_coord),
        .not_empty   (not_empty),
        .hold        (hold),
        .pop         (pop),
        .entry       (entry),
        .commit_value(commit_value),
        .commit_valid(commit_valid)
    );

endmodule

/* tb/keypad_matrix.sv */
`timescale 1ns/1ps

module keypad_matrix (
    input  logic [3:0] col_out,
    input  logic       key_a_down,
    input  logic [1:0] key_a_row,
    input  logic [1:0] key_a_col,
    input  logic [2:0] bounce_n,
    input  logic       key_b_down,
    input  logic [1:0] key_b_row,
    input  logic [1:0] key_b_col,
    output logic [3:0] row_in
);
    logic contact_a;

    // Key A chatters for bounce_n short pulses before it closes for good.
    initial begin
        contact_a = 1'b0;
        forever begin
            @(posedge key_a_down);
            repeat (bounce_n) begin
                contact_a = 1'b1;
                #37;
                contact_a = 1'b0;
                #23;
            end
            contact_a = 1'b1;
            @(negedge key_a_down);
            contact_a = 1'b0;
        end
    end

    // Line 0 is the MSB, so index ~n picks bit 3-n.
    always_comb begin
        row_in = 4'hf; // Pull-ups.
        if (contact_a && !col_out[~key_a_col]) begin
            row_in[~key_a_row] = 1'b0;
        end
        if (key_b_down && !col_out[~key_b_col]) begin
            row_in[~key_b_row] = 1'b0;
        end
    end

endmodule

/* tb/tb_keypad.sv */
`timescale 1ns/1ps

module tb_keypad;
    import keypad_pkg::*;

    localparam int DEBOUNCE       = 40;
    localparam int PRESS_CYCLES   = 150;
    localparam int SHORT_CYCLES   = 25;  // Well under the debounce period.
    localparam int RELEASE_CYCLES = 120;
    localparam int COMMIT_TIMEOUT = 2000;
    localparam int DRAIN_TIMEOUT  = 500;

    logic       clk;
    logic       rst_n;
    logic       hold;
    logic [3:0] row_in;
    logic [3:0] col_out;
    entry_t     entry;
    entry_t     commit_value;
    logic       commit_valid;
    logic       overflow;
    logic       key_a_down;
    logic [1:0] key_a_row;
    logic [1:0] key_a_col;
    logic [2:0] bounce_n;
    logic       key_b_down;
    logic [1:0] key_b_row;
    logic [1:0] key_b_col;

    key_coord_t hist[$];  // Every key the DUT should accept, in order.
    entry_t     exp_q[$]; // Commit values still to be seen.
    int         mismatch_cnt = 0;
    int         fail_cnt = 0;

    keypad_top #(.debounce_cycles(DEBOUNCE)) i_keypad_top (
        .clk(clk), .rst_n(rst_n), .row_in(row_in), .hold(hold), .col_out(col_out),
        .entry(entry), .commit_value(commit_value), .commit_valid(commit_valid),
        .overflow(overflow)
    );

    keypad_matrix i_keypad_matrix (
        .col_out(col_out), .key_a_down(key_a_down), .key_a_row(key_a_row),
        .key_a_col(key_a_col), .bounce_n(bounce_n), .key_b_down(key_b_down),
        .key_b_row(key_b_row), .key_b_col(key_b_col), .row_in(row_in)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic key_coord_t make_coord(input logic [1:0] r, input logic [1:0] c);
        return {~(4'b1000 >> r), ~(4'b1000 >> c)};
    endfunction

    // Replays the key history; returns the live entry and the value of the last commit.
    function automatic entry_t ref_model(input key_coord_t keys[$], output entry_t last_commit);
        entry_t   acc;
        key_val_t v;
        acc = '0;
        last_commit = '0;
        foreach (keys[i]) begin
            v = decode_key(keys[i]);
            if (v == KEY_STAR) begin
                acc = '0;
            end else if (v == KEY_HASH) begin
                last_commit = acc;
                acc = '0;
            end else begin
                acc = (acc << 4) | entry_t'(v);
            end
        end
        return acc;
    endfunction

    task automatic check_commit(input entry_t got, input entry_t want);
        if (got !== want) begin
            $display("mismatch at %0t ns: commit_value %h, expected %h", $time, got, want);
            mismatch_cnt++;
        end
    endtask

    task automatic check_entry(input entry_t got, input entry_t want);
        if (got !== want) begin
            $display("mismatch at %0t ns: entry %h, expected %h", $time, got, want);
            mismatch_cnt++;
        end
    endtask

    task automatic check_flag(input logic got, input logic want);
        if (got !== want) begin
            $display("mismatch at %0t ns: overflow %b, expected %b", $time, got, want);
            mismatch_cnt++;
        end
    endtask

    task automatic check_cols(input logic [3:0] got, input logic [3:0] want);
        if (got !== want) begin
            $display("mismatch at %0t ns: col_out %b, expected %b", $time, got, want);
            mismatch_cnt++;
        end
    endtask

    task automatic pick_key(output logic [1:0] r, output logic [1:0] c);
        key_val_t v;
        v = KEY_STAR;
        while (v == KEY_STAR || v == KEY_HASH) begin
            r = 2'($urandom_range(3, 0));
            c = 2'($urandom_range(3, 0));
            v = decode_key(make_coord(r, c));
        end
    endtask

    task automatic press_key(input logic [1:0] r, input logic [1:0] c, input int bounces,
                             input int down_cycles, input bit record);
        if (record) begin
            hist.push_back(make_coord(r, c));
        end
        key_a_row  = r;
        key_a_col  = c;
        bounce_n   = 3'(bounces);
        key_a_down = 1'b1;
        repeat (down_cycles) @(negedge clk);
        key_a_down = 1'b0;
        repeat (RELEASE_CYCLES) @(negedge clk);
    endtask

    task automatic press_chord(input logic [1:0] r, input logic [1:0] c,
                               input logic [1:0] r2, input logic [1:0] c2);
        key_b_row  = r2;
        key_b_col  = c2;
        key_b_down = 1'b1;
        press_key(r, c, 0, PRESS_CYCLES, 1'b0);
        key_b_down = 1'b0;
        repeat (RELEASE_CYCLES) @(negedge clk); // Scanner needs all rows high again.
    endtask

    task automatic expect_latest_commit();
        entry_t last;
        void'(ref_model(hist, last));
        exp_q.push_back(last);
    endtask

    task automatic commit_key(input int bounces);
        hist.push_back(make_coord(2'd3, 2'd2));
        expect_latest_commit();
        press_key(2'd3, 2'd2, bounces, PRESS_CYCLES, 1'b0);
    endtask

    task automatic check_live_entry();
        int     waited;
        entry_t last;
        waited = 0;
        while ((i_keypad_top.not_empty || exp_q.size() != 0) && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (i_keypad_top.not_empty || exp_q.size() != 0) begin
            $display("keys or commits still pending after %0d cycles at %0t", waited, $time);
            fail_cnt++;
        end
        @(negedge clk);
        check_entry(entry, ref_model(hist, last));
        check_cols(col_out, 4'h0); // Idle scanner drives all columns.
    endtask

    // Compares every commit against the queue of expected values.
    initial begin : compare_commits
        int     waited;
        entry_t want;
        forever begin
            @(negedge clk);
            if (exp_q.size() != 0) begin
                waited = 0;
                while (!commit_valid && waited < COMMIT_TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                want = exp_q.pop_front();
                if (commit_valid) begin
                    check_commit(commit_value, want);
                end else begin
                    $display("no commit seen for expected value %h by %0t", want, $time);
                    fail_cnt++;
                end
            end else if (commit_valid) begin
                $display("unexpected commit of %h at %0t", commit_value, $time);
                fail_cnt++;
            end
        end
    end

    initial begin : stimulus
        logic [1:0] r;
        logic [1:0] c;
        logic [1:0] r2;
        logic [1:0] c2;
        void'($urandom(43));
        rst_n      = 1'b0;
        hold       = 1'b0;
        key_a_down = 1'b0;
        key_a_row  = 2'd0;
        key_a_col  = 2'd0;
        bounce_n   = 3'd0;
        key_b_down = 1'b0;
        key_b_row  = 2'd0;
        key_b_col  = 2'd0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (5) @(negedge clk);
        check_cols(col_out, 4'h0);

        repeat (4) begin
            pick_key(r, c);
            press_key(r, c, 0, PRESS_CYCLES, 1'b1);
        end
        commit_key(0);
        check_live_entry();

        // Six keys keep the last four, then * wipes three.
        repeat (6) begin
            pick_key(r, c);
            press_key(r, c, 0, PRESS_CYCLES, 1'b1);
        end
        commit_key(0);
        repeat (3) begin
            pick_key(r, c);
            press_key(r, c, 0, PRESS_CYCLES, 1'b1);
        end
        press_key(2'd3, 2'd0, 0, PRESS_CYCLES, 1'b1);
        repeat (2) begin
            pick_key(r, c);
            press_key(r, c, 0, PRESS_CYCLES, 1'b1);
        end
        commit_key(0);
        check_live_entry();

        repeat (4) begin
            pick_key(r, c);
            press_key(r, c, int'($urandom_range(4, 1)), PRESS_CYCLES, 1'b1);
            pick_key(r, c);
            press_key(r, c, 0, SHORT_CYCLES, 1'b0);
        end
        commit_key(2);
        check_live_entry();

        pick_key(r, c);
        press_key(r, c, 0, PRESS_CYCLES, 1'b1);
        pick_key(r, c);
        pick_key(r2, c2);
        while (r2 == r && c2 == c) begin
            pick_key(r2, c2);
        end
        press_chord(r, c, r2, c2);
        pick_key(r, c);
        press_key(r, c, 0, PRESS_CYCLES, 1'b1);
        commit_key(0);
        check_live_entry();

        // Fill the FIFO while the consumer is held.
        check_flag(overflow, 1'b0);
        hold = 1'b1;
        repeat (7) begin
            pick_key(r, c);
            press_key(r, c, 0, PRESS_CYCLES, 1'b1);
        end
        press_key(2'd3, 2'd2, 0, PRESS_CYCLES, 1'b1);
        check_flag(overflow, 1'b0);
        pick_key(r, c);
        press_key(r, c, 0, PRESS_CYCLES, 1'b0); // Dropped.
        check_flag(overflow, 1'b1);
        expect_latest_commit();
        hold = 1'b0;
        check_live_entry();

        $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* keypad_entry.f */
src/keypad_pkg.sv
src/keypad_scan.sv
src/key_fifo.sv
src/digit_entry.sv
src/keypad_top.sv
tb/keypad_matrix.sv
tb/tb_keypad.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the keypad testbench with Verilator, run it, then scan the log for failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_keypad -Mdir obj_dir \
    -f keypad_entry.f > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_keypad > sim.log 2>&1 \
    || { echo "Simulation did not run to completion, see sim.log"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log \
    && { echo "Simulation reported failure, see sim.log"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "No pass message in sim.log"; exit 1; }
